// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/rob_macros.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/modn_counter.sv
`timescale 1ns/1ns
`default_nettype none

// Wrapping pointer, counts 0 .. N-1
module modn_counter #(
    parameter int N = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,                     // Advance by one
    input  logic                 clr_i,                    // Back to zero, wins over en_i
    output logic [$clog2(N)-1:0] count_o
);

    localparam int            W    = $clog2(N);
    localparam logic [W-1:0]  LAST = W'(N - 1);            // Wrap point

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;
        end else if (en_i) begin
            if (count_o == LAST) begin
                count_o <= '0;                             // Wrap around
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rob.sv
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module rob (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,

    // Issue
    input  logic                             issue_valid_i,
    output logic                             issue_ready_o,
    input  var rob_pkg::issue_req_t          issue_req_i,
    output logic [rob_pkg::ROB_IDX_LEN-1:0]  issue_tail_idx_o,  // Entry this push takes

    // CDB, always accepted
    input  logic                             cdb_valid_i,
    input  var rob_pkg::cdb_data_t           cdb_data_i,

    // Operand read ports
    input  logic [rob_pkg::ROB_IDX_LEN-1:0]  rs1_idx_i,
    input  logic [rob_pkg::ROB_IDX_LEN-1:0]  rs2_idx_i,
    output logic                             rs1_ready_o,
    output logic [`XLEN-1:0]                 rs1_value_o,
    output logic                             rs2_ready_o,
    output logic [`XLEN-1:0]                 rs2_value_o,

    // Commit
    input  logic                             comm_ready_i,
    output logic                             comm_valid_o,
    output rob_pkg::comm_data_t              comm_data_o,

    output logic                             exc_flush_o
);

    import rob_pkg::*;

    logic [ROB_IDX_LEN-1:0] head_idx, tail_idx;
    logic                   push, pop, clear;
    logic                   head_en, tail_en;
    logic                   tail_busy, head_valid, head_res_ready, head_except;

    assign issue_tail_idx_o = tail_idx;

    rob_ctrl u_ctrl (
        .clk_i, .rst_n_i, .flush_i,
        .issue_valid_i, .issue_ready_o, .comm_ready_i, .comm_valid_o,
        .tail_busy_i(tail_busy), .head_valid_i(head_valid),
        .head_res_ready_i(head_res_ready), .head_except_i(head_except),
        .push_o(push), .pop_o(pop), .clear_o(clear),
        .head_en_o(head_en), .tail_en_o(tail_en), .exc_flush_o
    );

    modn_counter #(.N(`ROB_DEPTH)) head_counter (
        .clk_i, .rst_n_i, .en_i(head_en), .clr_i(clear), .count_o(head_idx)
    );

    modn_counter #(.N(`ROB_DEPTH)) tail_counter (
        .clk_i, .rst_n_i, .en_i(tail_en), .clr_i(clear), .count_o(tail_idx)
    );

    rob_store u_store (
        .clk_i, .rst_n_i,
        .push_i(push), .pop_i(pop), .clear_i(clear),
        .head_idx_i(head_idx), .tail_idx_i(tail_idx),
        .issue_req_i, .cdb_valid_i, .cdb_data_i,
        .rs1_idx_i, .rs2_idx_i, .rs1_ready_o, .rs1_value_o, .rs2_ready_o, .rs2_value_o,
        .tail_busy_o(tail_busy), .head_valid_o(head_valid),
        .head_res_ready_o(head_res_ready), .head_except_o(head_except),
        .comm_data_o
    );

endmodule

`default_nettype wire

// File: logic/rob_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module rob_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,                                  // External flush, level

    input  logic issue_valid_i,
    output logic issue_ready_o,
    input  logic comm_ready_i,
    output logic comm_valid_o,

    // Status of head and tail entries
    input  logic tail_busy_i,
    input  logic head_valid_i,
    input  logic head_res_ready_i,
    input  logic head_except_i,

    // Entry store control
    output logic push_o,
    output logic pop_o,
    output logic clear_o,                                  // Also clears both pointers

    output logic head_en_o,
    output logic tail_en_o,

    output logic exc_flush_o                               // One cycle pulse
);

    import rob_pkg::*;

    rob_state_e state_q, state_d;
    logic       run;                                       // Normal operation this cycle

    assign run = (state_q == ROB_RUN) && !flush_i;

    // Issue side: room at the tail
    assign issue_ready_o = run && !tail_busy_i;
    assign push_o        = issue_ready_o && issue_valid_i;
    assign tail_en_o     = push_o;

    // Commit side
    assign comm_valid_o  = run && head_valid_i && head_res_ready_i;  // Oldest has its result
    assign pop_o         = comm_valid_o && comm_ready_i;
    assign head_en_o     = pop_o;

    // Either flush source empties the whole buffer
    assign clear_o     = flush_i || (state_q == ROB_FLUSH);
    assign exc_flush_o = (state_q == ROB_FLUSH);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ROB_RUN: begin
                // Excepting instruction leaves, throw away everything younger
                if (pop_o && head_except_i) begin
                    state_d = ROB_FLUSH;
                end
            end
            ROB_FLUSH: begin
                state_d = ROB_RUN;                         // Clear happens at this edge
            end
            default: begin
                state_d = ROB_RUN;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ROB_RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_macros.svh
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// Number of ROB entries, keep it a power of two
`define ROB_DEPTH 8

// Data path and PC width
`define XLEN 32

// Instruction width
`define ILEN 32

// Architectural register index width
`define REG_IDX_LEN 5

// Raw exception code width, as delivered by issue and CDB
`define ROB_EXCEPT_LEN 4

`endif

// File: logic/rob_pkg.sv
`default_nettype none
`include "rob_macros.svh"

package rob_pkg;

    localparam int ROB_IDX_LEN = $clog2(`ROB_DEPTH);       // Bits to address one entry

    // Exception causes handed to the commit logic
    typedef enum logic [`ROB_EXCEPT_LEN-1:0] {
        I_ADDR_MISALIGNED   = 4'h0,
        I_ACCESS_FAULT      = 4'h1,
        ILLEGAL_INSTRUCTION = 4'h2,
        BREAKPOINT          = 4'h3,
        LD_ADDR_MISALIGNED  = 4'h4,
        LD_ACCESS_FAULT     = 4'h5,
        ST_ADDR_MISALIGNED  = 4'h6,
        ST_ACCESS_FAULT     = 4'h7,
        ENV_CALL_UMODE      = 4'h8,
        ENV_CALL_SMODE      = 4'h9,
        UNKNOWN             = 4'ha,                        // Also stands in for raw code 14
        ENV_CALL_MMODE      = 4'hb,
        INSTR_PAGE_FAULT    = 4'hc,
        LD_PAGE_FAULT       = 4'hd,
        ST_PAGE_FAULT       = 4'hf
    } except_code_t;

    // Controller states
    typedef enum logic {
        ROB_RUN,                                           // Normal issue and commit
        ROB_FLUSH                                          // One cycle self flush after exception
    } rob_state_e;

    typedef struct packed {
        logic [`ILEN-1:0]           instr;
        logic [`XLEN-1:0]           pc;
        logic [`REG_IDX_LEN-1:0]    rd_idx;
        logic                       except_raised;
        logic [`ROB_EXCEPT_LEN-1:0] except_code;           // Raw code
        logic [`XLEN-1:0]           except_aux;            // Faulting address or early result
        logic                       res_ready;             // Result already known at issue
    } issue_req_t;

    typedef struct packed {
        logic [ROB_IDX_LEN-1:0]     rob_idx;               // Target entry
        logic [`XLEN-1:0]           value;
        logic                       except_raised;
        logic [`ROB_EXCEPT_LEN-1:0] except_code;
    } cdb_data_t;

    typedef struct packed {
        logic [`ILEN-1:0]           instr;
        logic [`XLEN-1:0]           pc;
        logic [`REG_IDX_LEN-1:0]    rd_idx;
        logic [`XLEN-1:0]           value;
        logic                       except_raised;
        except_code_t               except_code;           // Decoded cause
        logic [ROB_IDX_LEN-1:0]     head_idx;              // Needed to release register status
    } comm_data_t;

    typedef struct packed {
        logic                       valid;
        logic                       res_ready;
        logic [`ILEN-1:0]           instr;
        logic [`XLEN-1:0]           pc;
        logic [`REG_IDX_LEN-1:0]    rd_idx;
        logic [`XLEN-1:0]           value;
        logic                       except_raised;
        logic [`ROB_EXCEPT_LEN-1:0] except_code;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: logic/rob_store.sv
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module rob_store (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    input  logic                             push_i,
    input  logic                             pop_i,
    input  logic                             clear_i,

    input  logic [rob_pkg::ROB_IDX_LEN-1:0]  head_idx_i,
    input  logic [rob_pkg::ROB_IDX_LEN-1:0]  tail_idx_i,

    input  var rob_pkg::issue_req_t          issue_req_i,

    input  logic                             cdb_valid_i,
    input  var rob_pkg::cdb_data_t           cdb_data_i,

    // Operand forwarding to issue
    input  logic [rob_pkg::ROB_IDX_LEN-1:0]  rs1_idx_i,
    input  logic [rob_pkg::ROB_IDX_LEN-1:0]  rs2_idx_i,
    output logic                             rs1_ready_o,
    output logic [`XLEN-1:0]                 rs1_value_o,
    output logic                             rs2_ready_o,
    output logic [`XLEN-1:0]                 rs2_value_o,

    // Status to the controller
    output logic                             tail_busy_o,
    output logic                             head_valid_o,
    output logic                             head_res_ready_o,
    output logic                             head_except_o,

    output rob_pkg::comm_data_t              comm_data_o
);

    import rob_pkg::*;

    rob_entry_t rob_data [`ROB_DEPTH];
    rob_entry_t head_entry;                                // Oldest instruction

    assign head_entry = rob_data[head_idx_i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            foreach (rob_data[i]) begin
                rob_data[i] <= '0;
            end
        end else if (clear_i) begin
            // Status bits are enough, payload is dead once invalid
            foreach (rob_data[i]) begin
                rob_data[i].valid         <= 1'b0;
                rob_data[i].res_ready     <= 1'b0;
                rob_data[i].except_raised <= 1'b0;
            end
        end else begin
            // Issue write port
            if (push_i) begin
                rob_data[tail_idx_i].valid         <= 1'b1;
                rob_data[tail_idx_i].instr         <= issue_req_i.instr;
                rob_data[tail_idx_i].pc            <= issue_req_i.pc;
                rob_data[tail_idx_i].rd_idx        <= issue_req_i.rd_idx;
                rob_data[tail_idx_i].except_raised <= issue_req_i.except_raised;
                rob_data[tail_idx_i].except_code   <= issue_req_i.except_code;
                if (issue_req_i.except_raised || issue_req_i.res_ready) begin
                    rob_data[tail_idx_i].value     <= issue_req_i.except_aux;  // Aux data as result
                    rob_data[tail_idx_i].res_ready <= 1'b1;
                end else begin
                    rob_data[tail_idx_i].res_ready <= 1'b0;  // Wait for the CDB
                end
            end

            // CDB write port, later in the block so it wins on the same entry
            if (cdb_valid_i) begin
                rob_data[cdb_data_i.rob_idx].res_ready     <= 1'b1;
                rob_data[cdb_data_i.rob_idx].value         <= cdb_data_i.value;
                rob_data[cdb_data_i.rob_idx].except_raised <= cdb_data_i.except_raised;
                rob_data[cdb_data_i.rob_idx].except_code   <= cdb_data_i.except_code;
            end

            // Retire the head
            if (pop_i) begin
                rob_data[head_idx_i].valid <= 1'b0;
            end
        end
    end

    // Read ports
    assign rs1_ready_o = rob_data[rs1_idx_i].res_ready;
    assign rs1_value_o = rob_data[rs1_idx_i].value;
    assign rs2_ready_o = rob_data[rs2_idx_i].res_ready;
    assign rs2_value_o = rob_data[rs2_idx_i].value;

    assign tail_busy_o      = rob_data[tail_idx_i].valid;  // Full when the tail is still taken
    assign head_valid_o     = head_entry.valid;
    assign head_res_ready_o = head_entry.res_ready;
    assign head_except_o    = head_entry.except_raised;

    // Commit bundle with raw code translated to a cause
    always_comb begin
        comm_data_o.instr         = head_entry.instr;
        comm_data_o.pc            = head_entry.pc;
        comm_data_o.rd_idx        = head_entry.rd_idx;
        comm_data_o.value         = head_entry.value;
        comm_data_o.except_raised = head_entry.except_raised;
        comm_data_o.head_idx      = head_idx_i;
        case (head_entry.except_code)
            4'h0:    comm_data_o.except_code = I_ADDR_MISALIGNED;
            4'h1:    comm_data_o.except_code = I_ACCESS_FAULT;
            4'h2:    comm_data_o.except_code = ILLEGAL_INSTRUCTION;
            4'h3:    comm_data_o.except_code = BREAKPOINT;
            4'h4:    comm_data_o.except_code = LD_ADDR_MISALIGNED;
            4'h5:    comm_data_o.except_code = LD_ACCESS_FAULT;
            4'h6:    comm_data_o.except_code = ST_ADDR_MISALIGNED;
            4'h7:    comm_data_o.except_code = ST_ACCESS_FAULT;
            4'h8:    comm_data_o.except_code = ENV_CALL_UMODE;
            4'h9:    comm_data_o.except_code = ENV_CALL_SMODE;
            4'hb:    comm_data_o.except_code = ENV_CALL_MMODE;
            4'hc:    comm_data_o.except_code = INSTR_PAGE_FAULT;
            4'hd:    comm_data_o.except_code = LD_PAGE_FAULT;
            4'hf:    comm_data_o.except_code = ST_PAGE_FAULT;
            default: comm_data_o.except_code = UNKNOWN;    // Reserved codes 10 and 14
        endcase
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/rob_pkg.sv
logic/modn_counter.sv
logic/rob_ctrl.sv
logic/rob_store.sv
logic/rob.sv
tb/tb_rob.sv

// File: tb/tb_rob.sv
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module tb_rob;

    import rob_pkg::*;

    localparam int DEPTH       = `ROB_DEPTH;
    localparam int CYCLE_LIMIT = 4000;                     // About eight times the expected run

    logic                   clk_i, rst_n_i, flush_i;
    logic                   issue_valid_i, issue_ready_o;
    issue_req_t             issue_req_i;
    logic [ROB_IDX_LEN-1:0] issue_tail_idx_o;
    logic                   cdb_valid_i;
    cdb_data_t              cdb_data_i;
    logic [ROB_IDX_LEN-1:0] rs1_idx_i, rs2_idx_i;
    logic                   rs1_ready_o, rs2_ready_o;
    logic [`XLEN-1:0]       rs1_value_o, rs2_value_o;
    logic                   comm_ready_i, comm_valid_o;
    comm_data_t             comm_data_o;
    logic                   exc_flush_o;

    // Reference model, indexed like the ROB
    rob_entry_t             m_rob [DEPTH];
    logic [ROB_IDX_LEN-1:0] m_head, m_tail;
    logic                   m_flushing;                    // Self flush cycle after exception

    int    cycles = 0;
    int    comm_mode;                                      // 0 hold, 1 random stalls, 2 always ready
    string test_name;

    rob UUT (.*);

    always #50 clk_i = ~clk_i;

    function automatic except_code_t cause_of(input logic [3:0] raw);
        if (raw == 4'd10 || raw == 4'd14) begin
            return UNKNOWN;                                // Reserved codes
        end
        return except_code_t'(raw);
    endfunction

    function automatic logic exp_issue_ready();
        return !m_flushing && !flush_i && !m_rob[m_tail].valid;
    endfunction

    function automatic logic exp_comm_valid();
        return !m_flushing && !flush_i && m_rob[m_head].valid && m_rob[m_head].res_ready;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("TESTBENCH FAILED");
            $display("ERROR test %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $fatal(1, "Check failed");
        end
    endtask

    task automatic check_operand(input string port, input logic [ROB_IDX_LEN-1:0] idx,
                                 input logic ready, input logic [`XLEN-1:0] value);
        if (m_rob[idx].valid) begin                        // Free entries hold stale data
            check({port, "_ready"}, 32'(m_rob[idx].res_ready), 32'(ready));
            if (m_rob[idx].res_ready) begin
                check({port, "_value"}, m_rob[idx].value, value);
            end
        end
    endtask

    // Model update, sees inputs as they were before the edge
    always @(posedge clk_i or negedge rst_n_i) begin : model_update
        logic do_push;
        logic do_pop;
        logic pop_exc;
        if (!rst_n_i) begin
            foreach (m_rob[i]) begin
                m_rob[i] = '0;
            end
            m_head     = '0;
            m_tail     = '0;
            m_flushing = 1'b0;
        end else begin
            do_push = exp_issue_ready() && issue_valid_i;
            do_pop  = exp_comm_valid() && comm_ready_i;
            pop_exc = m_rob[m_head].except_raised;
            if (flush_i || m_flushing) begin
                foreach (m_rob[i]) begin
                    m_rob[i].valid         = 1'b0;
                    m_rob[i].res_ready     = 1'b0;
                    m_rob[i].except_raised = 1'b0;
                end
                m_head     = '0;
                m_tail     = '0;
                m_flushing = 1'b0;
            end else begin
                if (do_push) begin
                    m_rob[m_tail].valid         = 1'b1;
                    m_rob[m_tail].instr         = issue_req_i.instr;
                    m_rob[m_tail].pc            = issue_req_i.pc;
                    m_rob[m_tail].rd_idx        = issue_req_i.rd_idx;
                    m_rob[m_tail].except_raised = issue_req_i.except_raised;
                    m_rob[m_tail].except_code   = issue_req_i.except_code;
                    m_rob[m_tail].res_ready     = issue_req_i.res_ready ||
                                                  issue_req_i.except_raised;
                    if (m_rob[m_tail].res_ready) begin
                        m_rob[m_tail].value = issue_req_i.except_aux;  // Known at issue
                    end
                end
                if (cdb_valid_i) begin                     // CDB wins over a push
                    m_rob[cdb_data_i.rob_idx].res_ready     = 1'b1;
                    m_rob[cdb_data_i.rob_idx].value         = cdb_data_i.value;
                    m_rob[cdb_data_i.rob_idx].except_raised = cdb_data_i.except_raised;
                    m_rob[cdb_data_i.rob_idx].except_code   = cdb_data_i.except_code;
                end
                if (do_pop) begin
                    m_rob[m_head].valid = 1'b0;
                    m_head              = m_head + 1'b1;
                    m_flushing          = pop_exc;
                end
                if (do_push) begin
                    m_tail = m_tail + 1'b1;
                end
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            check("issue_ready_o", 32'(exp_issue_ready()), 32'(issue_ready_o));
            check("issue_tail_idx_o", 32'(m_tail), 32'(issue_tail_idx_o));
            check("comm_valid_o", 32'(exp_comm_valid()), 32'(comm_valid_o));
            check("exc_flush_o", 32'(m_flushing), 32'(exc_flush_o));
            check_operand("rs1", rs1_idx_i, rs1_ready_o, rs1_value_o);
            check_operand("rs2", rs2_idx_i, rs2_ready_o, rs2_value_o);
            if (exp_comm_valid()) begin                    // Head bundle in push order
                check("comm instr", m_rob[m_head].instr, comm_data_o.instr);
                check("comm pc", m_rob[m_head].pc, comm_data_o.pc);
                check("comm rd_idx", 32'(m_rob[m_head].rd_idx), 32'(comm_data_o.rd_idx));
                check("comm value", m_rob[m_head].value, comm_data_o.value);
                check("comm except_raised", 32'(m_rob[m_head].except_raised),
                      32'(comm_data_o.except_raised));
                check("comm except_code", 32'(cause_of(m_rob[m_head].except_code)),
                      32'(comm_data_o.except_code));
                check("comm head_idx", 32'(m_head), 32'(comm_data_o.head_idx));
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("TESTBENCH FAILED");
            $display("Timeout after %0d cycles, the DUT stopped making progress", CYCLE_LIMIT);
            $fatal(1, "Run hung");
        end
    end

    task automatic tick();
        @(posedge clk_i);
        rs1_idx_i    <= ROB_IDX_LEN'($urandom);            // Probe random entries
        rs2_idx_i    <= ROB_IDX_LEN'($urandom);
        comm_ready_i <= (comm_mode == 2) || (comm_mode == 1 && $urandom_range(2, 0) != 0);
    endtask

    function automatic issue_req_t rand_req(input logic early, input logic exc,
                                            input logic [3:0] code);
        issue_req_t  r;
        logic [31:0] rnd;
        rnd             = $urandom;
        r.instr         = $urandom;
        r.pc            = $urandom;
        r.rd_idx        = rnd[`REG_IDX_LEN-1:0];
        r.except_aux    = $urandom;
        r.res_ready     = early;
        r.except_raised = exc;
        r.except_code   = code;
        return r;
    endfunction

    // Holds the request until the ROB takes it
    task automatic push(input issue_req_t req, output logic [ROB_IDX_LEN-1:0] idx);
        tick();
        issue_valid_i <= 1'b1;
        issue_req_i   <= req;
        @(negedge clk_i);
        while (!issue_ready_o) begin
            @(negedge clk_i);
        end
        idx = issue_tail_idx_o;
        tick();
        issue_valid_i <= 1'b0;
    endtask

    task automatic cdb_write(input logic [ROB_IDX_LEN-1:0] idx, input logic exc,
                             input logic [3:0] code);
        tick();
        cdb_valid_i <= 1'b1;
        cdb_data_i  <= '{rob_idx: idx, value: $urandom, except_raised: exc, except_code: code};
        tick();
        cdb_valid_i <= 1'b0;
    endtask

    task automatic drain();
        comm_mode = 2;
        tick();
        @(negedge clk_i);
        while (m_rob[m_head].valid || m_flushing) begin
            @(negedge clk_i);
        end
    endtask

    // Fill, then complete out of order with random commit stalls
    task automatic run_round(input int n, input logic from_zero);
        logic [ROB_IDX_LEN-1:0] idx;
        logic [ROB_IDX_LEN-1:0] order [$];
        logic                   early;
        int                     j;
        comm_mode = 0;
        for (int i = 0; i < n; i++) begin
            early = ($urandom_range(3, 0) == 0);
            push(rand_req(early, 1'b0, 4'h0), idx);
            if (from_zero) begin
                check("tail index", 32'(i), 32'(idx));
            end
            if (!early) begin
                order.push_back(idx);
            end
        end
        if (from_zero && n == DEPTH) begin
            @(negedge clk_i);
            check("issue_ready_o when full", 32'd0, 32'(issue_ready_o));
        end
        comm_mode = 1;
        while (order.size() > 0) begin
            j = $urandom_range(order.size() - 1, 0);
            cdb_write(order[j], 1'b0, 4'h0);
            order.delete(j);
        end
        drain();
    endtask

    // Second of four entries excepts, the two behind it must vanish
    task automatic run_exception(input logic [3:0] code, input logic at_issue);
        logic [ROB_IDX_LEN-1:0] idx;
        logic [ROB_IDX_LEN-1:0] order [$];
        comm_mode = 0;
        for (int i = 0; i < 4; i++) begin
            push(rand_req(1'b0, at_issue && i == 1, code), idx);
            if (!(at_issue && i == 1)) begin
                order.push_back(idx);
            end
        end
        foreach (order[k]) begin
            cdb_write(order[k], !at_issue && k == 1, code);
        end
        drain();
        check("tail after exception flush", 32'd0, 32'(issue_tail_idx_o));
    endtask

    initial begin
        logic [ROB_IDX_LEN-1:0] idx;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_req_i   = '0;
        cdb_valid_i   = 1'b0;
        cdb_data_i    = '0;
        rs1_idx_i     = '0;
        rs2_idx_i     = '0;
        comm_ready_i  = 1'b0;
        comm_mode     = 0;
        void'($urandom(32'h3cac76dd));
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        test_name = "reset_fill";
        run_round(DEPTH, 1'b1);
        test_name = "ooo_commit";
        repeat (4) run_round(DEPTH, 1'b0);                 // Wraps both pointers
        test_name = "exception";
        for (int c = 0; c < 16; c++) begin
            run_exception(4'(c), c[0]);                    // Odd codes at issue, even from CDB
        end

        test_name = "ext_flush";
        comm_mode = 0;
        for (int i = 0; i < 5; i++) begin
            push(rand_req(i == 2, 1'b0, 4'h0), idx);
        end
        cdb_write(3'(0), 1'b0, 4'h0);                      // Head ready, flush must beat commit
        comm_mode = 1;
        tick();
        flush_i <= 1'b1;
        tick();
        flush_i <= 1'b0;
        run_round(DEPTH, 1'b1);                            // Tail restarts at 0

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
